// File: Bender.yml
package:
  name: bpu

sources:
  - design/bpu_pkg.sv
  - design/bpu_pipe_reg.sv
  - design/bpu_btb.sv
  - design/bpu_bht.sv
  - design/bpu_ras.sv
  - design/bpu_select.sv
  - design/bpu_top.sv
  - target: test
    files:
      - dv/tb_bpu.sv

// File: design/bpu_bht.sv
module bpu_bht (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic [bpu_pkg::XLEN-1:0]     lookup_pc_i,
  output logic                         taken_o,
  input  bpu_pkg::update_t             update_i,
  output logic [bpu_pkg::GHR_BITS-1:0] ghr_o
);

  import bpu_pkg::*;

  logic [1:0]              ctr_q [BHT_ENTRIES];
  logic [GHR_BITS-1:0]     ghr_q;
  logic [BHT_IDX_BITS-1:0] ghr_ext;
  logic [BHT_IDX_BITS-1:0] rd_idx;
  logic [BHT_IDX_BITS-1:0] wr_idx;
  logic [1:0]              wr_ctr;
  logic                    wr_en;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // gshare index
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign ghr_ext = BHT_IDX_BITS'(ghr_q);
  assign rd_idx  = lookup_pc_i[2 +: BHT_IDX_BITS] ^ ghr_ext;
  assign wr_idx  = update_i.pc[2 +: BHT_IDX_BITS] ^ ghr_ext;  // history before this shift

  assign taken_o = ctr_q[rd_idx][1];
  assign ghr_o   = ghr_q;

  assign wr_en = update_i.valid && update_i.is_cond;

  always_comb begin
    wr_ctr = ctr_q[wr_idx];
    if (update_i.taken && wr_ctr != 2'b11) begin
      wr_ctr = wr_ctr + 2'b01;
    end else if (!update_i.taken && wr_ctr != 2'b00) begin
      wr_ctr = wr_ctr - 2'b01;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        ctr_q[i] <= 2'b01;  // weakly not taken
      end
      ghr_q <= '0;
    end else if (wr_en) begin
      ctr_q[wr_idx] <= wr_ctr;
      ghr_q         <= {ghr_q[GHR_BITS-2:0], update_i.taken};
    end
  end

endmodule

// File: design/bpu_btb.sv
module bpu_btb (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [bpu_pkg::XLEN-1:0] lookup_pc_i,
  output logic                     hit_o,
  output bpu_pkg::br_kind_e        kind_o,
  output logic [bpu_pkg::XLEN-1:0] target_o,
  input  bpu_pkg::update_t         update_i
);

  import bpu_pkg::*;

  logic                    valid_q  [BTB_ENTRIES];
  logic [BTB_TAG_BITS-1:0] tag_q    [BTB_ENTRIES];
  br_kind_e                kind_q   [BTB_ENTRIES];
  logic [XLEN-1:0]         target_q [BTB_ENTRIES];

  logic [BTB_IDX_BITS-1:0] rd_idx;
  logic [BTB_TAG_BITS-1:0] rd_tag;
  logic [BTB_IDX_BITS-1:0] wr_idx;
  logic                    wr_en;
  br_kind_e                wr_kind;

  assign rd_idx = lookup_pc_i[2 +: BTB_IDX_BITS];
  assign rd_tag = lookup_pc_i[XLEN-1 -: BTB_TAG_BITS];

  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign kind_o   = kind_q[rd_idx];
  assign target_o = target_q[rd_idx];

  // not-taken conditionals never allocate
  assign wr_idx = update_i.pc[2 +: BTB_IDX_BITS];
  assign wr_en  = update_i.valid &&
                  (update_i.taken || update_i.is_call || update_i.is_ret || !update_i.is_cond);

  assign wr_kind = update_i.is_ret  ? RET  :
                   update_i.is_call ? CALL :
                   update_i.is_cond ? COND : JUMP;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (wr_en) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      tag_q[wr_idx]    <= update_i.pc[XLEN-1 -: BTB_TAG_BITS];
      kind_q[wr_idx]   <= wr_kind;
      target_q[wr_idx] <= update_i.target;
    end
  end

endmodule

// File: design/bpu_pipe_reg.sv
module bpu_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  payload_t data_q;

  // accept when empty or when the held item leaves this cycle
  assign in_ready_o = (~valid_q | out_ready_i) & ~flush_i;

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;  // in-flight item is dropped
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

endmodule

// File: design/bpu_pkg.sv
package bpu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int XLEN         = 32;
  localparam int BTB_ENTRIES  = 64;
  localparam int BTB_IDX_BITS = $clog2(BTB_ENTRIES);
  localparam int BTB_TAG_BITS = XLEN - 2 - BTB_IDX_BITS;  // pc bits above the index
  localparam int BHT_ENTRIES  = 256;
  localparam int BHT_IDX_BITS = $clog2(BHT_ENTRIES);
  localparam int GHR_BITS     = 8;
  localparam int RAS_DEPTH    = 4;
  localparam int RAS_PTR_BITS = $clog2(RAS_DEPTH);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    COND = 2'd0,
    JUMP = 2'd1,
    CALL = 2'd2,
    RET  = 2'd3
  } br_kind_e;

  typedef struct packed {
    logic [XLEN-1:0] pc;
  } fetch_req_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic            hit;
    br_kind_e        kind;
    logic [XLEN-1:0] target;
    logic            ctr_taken;     // upper bit of the gshare counter
    logic [XLEN-1:0] ras_top;
    logic            ras_nonempty;
  } lookup_t;

  typedef struct packed {
    logic [XLEN-1:0] npc;
    logic            taken;
  } pred_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic            is_cond;
    logic            taken;
    logic            is_call;
    logic            is_ret;
    logic [XLEN-1:0] target;
  } update_t;

endpackage

// File: design/bpu_ras.sv
module bpu_ras (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  bpu_pkg::update_t         update_i,
  output logic [bpu_pkg::XLEN-1:0] top_o,
  output logic                     nonempty_o
);

  import bpu_pkg::*;

  logic [XLEN-1:0]         stack_q [RAS_DEPTH];
  logic [RAS_PTR_BITS-1:0] ptr_q;  // next free slot
  logic [RAS_PTR_BITS:0]   cnt_q;
  logic [RAS_PTR_BITS-1:0] top_idx;
  logic                    push;
  logic                    pop;

  assign push = update_i.valid && update_i.is_call;
  assign pop  = update_i.valid && update_i.is_ret && !update_i.is_call;

  assign top_idx    = ptr_q - RAS_PTR_BITS'(1);
  assign top_o      = stack_q[top_idx];
  assign nonempty_o = (cnt_q != '0);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointer and occupancy
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
      cnt_q <= '0;
    end else if (push) begin
      ptr_q <= ptr_q + RAS_PTR_BITS'(1);  // wraps onto the oldest entry when full
      if (cnt_q != (RAS_PTR_BITS+1)'(RAS_DEPTH)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (pop && nonempty_o) begin
      ptr_q <= top_idx;
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      stack_q[ptr_q] <= update_i.pc + XLEN'(4);
    end
  end

endmodule

// File: design/bpu_select.sv
module bpu_select (
  input  bpu_pkg::lookup_t lookup_i,
  output bpu_pkg::pred_t   pred_o
);

  import bpu_pkg::*;

  logic [XLEN-1:0] fall_through;
  logic [XLEN-1:0] redirect_pc;
  logic            redirect;

  assign fall_through = lookup_i.pc + XLEN'(4);

  always_comb begin
    redirect    = 1'b0;
    redirect_pc = lookup_i.target;
    if (lookup_i.hit) begin
      unique case (lookup_i.kind)
        COND: begin
          redirect = lookup_i.ctr_taken;
        end
        JUMP, CALL: begin
          redirect = 1'b1;
        end
        RET: begin
          redirect = 1'b1;
          // empty stack falls back to the last recorded target
          if (lookup_i.ras_nonempty) begin
            redirect_pc = lookup_i.ras_top;
          end
        end
        default: begin
          redirect = 1'b0;
        end
      endcase
    end
  end

  assign pred_o.npc   = redirect ? redirect_pc : fall_through;
  assign pred_o.taken = redirect;

endmodule

// File: design/bpu_top.sv
module bpu_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  input  logic [bpu_pkg::XLEN-1:0]     req_pc_i,
  output logic                         pred_valid_o,
  input  logic                         pred_ready_i,
  output logic [bpu_pkg::XLEN-1:0]     pred_npc_o,
  output logic                         pred_taken_o,
  input  bpu_pkg::update_t             update_i,
  input  logic                         flush_i,
  output logic [bpu_pkg::GHR_BITS-1:0] ghr_o
);

  import bpu_pkg::*;

  fetch_req_t req_d;
  fetch_req_t req_q;
  logic       req_q_valid;
  logic       req_q_ready;
  lookup_t    lookup_d;
  lookup_t    lookup_q;
  pred_t      pred;

  assign req_d.pc = req_pc_i;

  bpu_pipe_reg #(.payload_t(fetch_req_t)) req_reg (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .in_valid_i (req_valid_i),
    .in_ready_o (req_ready_o),
    .in_data_i  (req_d),
    .out_valid_o(req_q_valid),
    .out_ready_i(req_q_ready),
    .out_data_o (req_q)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // table lookup on the request register output
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign lookup_d.pc = req_q.pc;

  bpu_btb u_btb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .lookup_pc_i(req_q.pc),
    .hit_o      (lookup_d.hit),
    .kind_o     (lookup_d.kind),
    .target_o   (lookup_d.target),
    .update_i   (update_i)
  );

  bpu_bht u_bht (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .lookup_pc_i(req_q.pc),
    .taken_o    (lookup_d.ctr_taken),
    .update_i   (update_i),
    .ghr_o      (ghr_o)
  );

  bpu_ras u_ras (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .update_i  (update_i),
    .top_o     (lookup_d.ras_top),
    .nonempty_o(lookup_d.ras_nonempty)
  );

  bpu_pipe_reg #(.payload_t(lookup_t)) res_reg (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .in_valid_i (req_q_valid),
    .in_ready_o (req_q_ready),
    .in_data_i  (lookup_d),
    .out_valid_o(pred_valid_o),
    .out_ready_i(pred_ready_i),
    .out_data_o (lookup_q)
  );

  bpu_select u_select (
    .lookup_i(lookup_q),
    .pred_o  (pred)
  );

  assign pred_npc_o   = pred.npc;
  assign pred_taken_o = pred.taken;

endmodule

// File: dv/tb_bpu.sv
module tb_bpu;

  import bpu_pkg::*;

  logic                clk_i;
  logic                rst_n_i;
  logic                req_valid_i;
  logic                req_ready_o;
  logic [XLEN-1:0]     req_pc_i;
  logic                pred_valid_o;
  logic                pred_ready_i;
  logic [XLEN-1:0]     pred_npc_o;
  logic                pred_taken_o;
  update_t             update_i;
  logic                flush_i;
  logic [GHR_BITS-1:0] ghr_o;
  int                  ready_mode;  // 0 always ready, 1 random stalls, 2 held low
  int                  cycles;
  int                  exp_cnt;
  pred_t               exp_head;
  pred_t               exp_q [$];
  logic                m_btb_v    [BTB_ENTRIES];
  logic [XLEN-1:0]     m_btb_pc   [BTB_ENTRIES];  // whole pc stands in for the tag
  br_kind_e            m_btb_kind [BTB_ENTRIES];
  logic [XLEN-1:0]     m_btb_tgt  [BTB_ENTRIES];
  logic [1:0]          m_ctr      [BHT_ENTRIES];
  logic [GHR_BITS-1:0] m_ghr;
  logic [XLEN-1:0]     m_ras [$];  // newest entry at the back

  bpu_top DUT (.*);

  always #50 clk_i = ~clk_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic pred_t predict(logic [XLEN-1:0] pc);
    pred_t p;
    int    b;
    int    h;
    b = pc[2 +: BTB_IDX_BITS];
    h = pc[2 +: BHT_IDX_BITS] ^ m_ghr;
    p.npc   = pc + 4;
    p.taken = 1'b0;
    if (m_btb_v[b] && m_btb_pc[b][XLEN-1:2] == pc[XLEN-1:2]) begin
      p.taken = (m_btb_kind[b] != COND) || m_ctr[h][1];
      if (p.taken) p.npc = m_btb_tgt[b];
      if (m_btb_kind[b] == RET && m_ras.size() != 0) p.npc = m_ras[$];
    end
    return p;
  endfunction

  task automatic model_update(update_t u);
    int b;
    int h;
    b = u.pc[2 +: BTB_IDX_BITS];
    h = u.pc[2 +: BHT_IDX_BITS] ^ m_ghr;
    if (u.taken || u.is_call || u.is_ret || !u.is_cond) begin
      m_btb_v[b]    = 1'b1;
      m_btb_pc[b]   = u.pc;
      m_btb_tgt[b]  = u.target;
      m_btb_kind[b] = u.is_ret ? RET : u.is_call ? CALL : u.is_cond ? COND : JUMP;
    end
    if (u.is_cond) begin
      if (u.taken && m_ctr[h] != 2'b11) m_ctr[h] = m_ctr[h] + 1;
      else if (!u.taken && m_ctr[h] != 2'b00) m_ctr[h] = m_ctr[h] - 1;
      m_ghr = {m_ghr[GHR_BITS-2:0], u.taken};
    end
    if (u.is_call) begin
      m_ras.push_back(u.pc + 4);
      if (m_ras.size() > RAS_DEPTH) void'(m_ras.pop_front());  // oldest is lost
    end else if (u.is_ret && m_ras.size() != 0) begin
      void'(m_ras.pop_back());
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // monitor and checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic report_mismatch(string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  always @(posedge clk_i) begin
    cycles++;
    if (cycles == 4000) begin  // roughly ten times the cycles the sequence needs
      $display("timeout: predictions stopped arriving");
      $display("TEST FAILED");
      $fatal(1);
    end
    if (rst_n_i) begin
      if (pred_valid_o && pred_ready_i && exp_q.size() != 0) void'(exp_q.pop_front());
      if (flush_i) exp_q.delete();
      if (update_i.valid) model_update(update_i);
      if (req_valid_i && req_ready_o) exp_q.push_back(predict(req_pc_i));
    end
    exp_cnt = exp_q.size();
    if (exp_cnt != 0) exp_head = exp_q[0];
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pred_valid_o && pred_ready_i |->
      exp_cnt != 0 && pred_npc_o == exp_head.npc && pred_taken_o == exp_head.taken)
  else report_mismatch($sformatf("prediction %h/%b, expected %h/%b with %0d pending",
    $sampled(pred_npc_o), $sampled(pred_taken_o), $sampled(exp_head.npc),
    $sampled(exp_head.taken), $sampled(exp_cnt)));

  assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    pred_valid_o && !pred_ready_i |=> pred_valid_o && $stable(pred_npc_o) && $stable(pred_taken_o))
  else report_mismatch("stalled prediction changed before it was taken");

  // two cycles from acceptance to the output when the result side keeps up
  assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
    req_valid_i && req_ready_o ##1 pred_ready_i |=> pred_valid_o)
  else report_mismatch("accepted request missed its output slot");

  // a request is refused only during a flush or when both stages are full and stalled
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_ready_o == (!flush_i && (pred_ready_i || exp_cnt < 2)))
  else report_mismatch($sformatf("request ready %b with %0d in flight",
    $sampled(req_ready_o), $sampled(exp_cnt)));

  assert property (@(posedge clk_i) disable iff (!rst_n_i) ghr_o == m_ghr)
  else report_mismatch($sformatf("history %h, expected %h", $sampled(ghr_o), $sampled(m_ghr)));

  always @(posedge clk_i) begin
    #10;
    pred_ready_i = (ready_mode == 0) || (ready_mode == 1 && ($urandom % 3) != 0);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic next_cycle();
    @(posedge clk_i);
    #10;
  endtask

  task automatic send_pc(logic [XLEN-1:0] pc);
    bit fired;
    fired       = 1'b0;
    req_valid_i = 1'b1;
    req_pc_i    = pc;
    while (!fired) begin
      @(posedge clk_i);
      fired = req_ready_o;  // value seen by the DUT at this edge
    end
    #10;
    req_valid_i = 1'b0;
  endtask

  task automatic drain_results();
    while (exp_cnt != 0) next_cycle();
    next_cycle();
  endtask

  task automatic train(logic [XLEN-1:0] pc, logic cond, logic tk, logic call, logic ret,
                       logic [XLEN-1:0] tgt);
    update_i = '{valid: 1'b1, pc: pc, is_cond: cond, taken: tk, is_call: call,
                 is_ret: ret, target: tgt};
    next_cycle();
    update_i.valid = 1'b0;
  endtask

  function automatic logic [XLEN-1:0] pick_pc();
    case ($urandom % 6)
      0: return 32'h0000_1010;
      1: return 32'h0000_2020;
      2: return 32'h0000_3030;
      3: return 32'h0000_4040;
      default: return $urandom & 32'h0003_fffc;
    endcase
  endfunction

  initial begin
    void'($urandom(96475));
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    req_valid_i  = 1'b0;
    req_pc_i     = '0;
    pred_ready_i = 1'b1;
    update_i     = '0;
    flush_i      = 1'b0;
    ready_mode   = 0;
    m_ghr        = '0;
    for (int i = 0; i < BTB_ENTRIES; i++) m_btb_v[i] = 1'b0;
    for (int i = 0; i < BHT_ENTRIES; i++) m_ctr[i] = 2'b01;
    repeat (4) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    assert (!pred_valid_o && req_ready_o && ghr_o == '0)
      else report_mismatch("outputs wrong after reset");
    repeat (8) send_pc(pick_pc());  // cold tables
    drain_results();
    repeat (10) train(32'h1010, 1'b1, 1'b1, 1'b0, 1'b0, 32'h8000);
    send_pc(32'h1010);
    drain_results();
    repeat (9) train(32'h1010, 1'b1, 1'b0, 1'b0, 1'b0, 32'h8000);
    send_pc(32'h1010);
    drain_results();
    train(32'h2020, 1'b0, 1'b1, 1'b0, 1'b0, 32'h5000);
    train(32'h3030, 1'b0, 1'b1, 1'b1, 1'b0, 32'h6000);
    send_pc(32'h2020);
    send_pc(32'h3030);
    drain_results();
    train(32'h4040, 1'b0, 1'b1, 1'b0, 1'b1, 32'h7000);  // empties the stack again
    for (int i = 0; i < 6; i++) train(32'h3030 + i * 32'h40, 1'b0, 1'b1, 1'b1, 1'b0, 32'h6000);
    repeat (5) begin
      send_pc(32'h4040);
      drain_results();
      train(32'h4040, 1'b0, 1'b1, 1'b0, 1'b1, 32'h7000);
    end
    ready_mode = 1;
    next_cycle();
    repeat (40) send_pc(pick_pc());
    drain_results();
    ready_mode = 0;
    next_cycle();
    repeat (20) send_pc(pick_pc());
    drain_results();
    ready_mode = 2;
    next_cycle();
    send_pc(32'h2020);
    send_pc(32'h3030);
    flush_i = 1'b1;
    next_cycle();
    flush_i    = 1'b0;
    ready_mode = 0;
    assert (!pred_valid_o) else report_mismatch("prediction survived the flush");
    repeat (3) next_cycle();
    send_pc(32'h2020);
    send_pc(32'h1010);
    drain_results();
    $display("TEST OK");
    $finish;
  end

endmodule

// File: filelist.f
design/bpu_pkg.sv
design/bpu_pipe_reg.sv
design/bpu_btb.sv
design/bpu_bht.sv
design/bpu_ras.sv
design/bpu_select.sv
design/bpu_top.sv
dv/tb_bpu.sv
